// File: rtl/fas_pkg.sv
package fas_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  parameter int sample_w  = 16;  // input and output sample width
  parameter int coef_w    = 20;  // coefficient width
  parameter int coef_frac = 16;  // fraction bits in a coefficient
  parameter int num_taps  = 32;  // filter length

  // 32 full products need 5 guard bits on top of the product width
  parameter int acc_w = sample_w + coef_w + 5;

  parameter int frame_len_default = 16;  // samples per frame

  typedef logic signed [sample_w-1:0] sample_t;
  typedef logic signed [coef_w-1:0]   coef_t;
  typedef logic signed [acc_w-1:0]    acc_t;

  // element 0 is the newest sample
  typedef sample_t window_t [num_taps];

  ////////////////////////////////////////////////////////////
  // symmetric low-pass taps, q4.16
  ////////////////////////////////////////////////////////////

  parameter coef_t fir_coef [num_taps] = '{
    20'hFFF9E, 20'hFFF86, 20'hFFFA7, 20'h0003B,  // -0.0015 .. 0.0009
    20'h0014B, 20'h0024A, 20'h00222, 20'hFFFE4,  // small side lobe
    20'hFFBC5, 20'hFF7CA, 20'hFF74E, 20'hFFD74,  // negative lobe
    20'h00B1A, 20'h01DAC, 20'h02F9E, 20'h03AA9,  // main lobe up to 0.2291
    20'h03AA9, 20'h02F9E, 20'h01DAC, 20'h00B1A,  // mirror of 15..12
    20'hFFD74, 20'hFF74E, 20'hFF7CA, 20'hFFBC5,
    20'hFFFE4, 20'h00222, 20'h0024A, 20'h0014B,
    20'h0003B, 20'hFFFA7, 20'hFFF86, 20'hFFF9E   // entry 31 equals entry 0
  };

endpackage

// File: rtl/fir_tap_line.sv
`timescale 1ns/100ps

module fir_tap_line (
  input  logic              clk,
  input  logic              rst,
  input  logic              data_valid,
  input  fas_pkg::sample_t  data,
  output fas_pkg::window_t  window,
  output logic              window_valid
);

  // counter only has to reach num_taps-1, then it sticks
  localparam int cnt_w = $clog2(fas_pkg::num_taps);
  localparam logic [cnt_w-1:0] fill_max = cnt_w'(fas_pkg::num_taps - 1);

  logic [cnt_w-1:0] fill_cnt;  // consecutive samples seen, saturating

  ////////////////////////////////////////////////////////////
  // delay line
  ////////////////////////////////////////////////////////////

  // shifts toward the old end on every accepted sample
  always_ff @(posedge clk) begin
    if (data_valid) begin
      window[0] <= data;  // newest
      for (int i = 1; i < fas_pkg::num_taps; i++) begin
        window[i] <= window[i-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // fill tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_cnt     <= '0;
      window_valid <= 1'b0;
    end else begin
      // fill_cnt == fill_max means 31 or more samples already in line,
      // so the sample taken now completes a full window
      window_valid <= data_valid && (fill_cnt == fill_max);

      if (!data_valid) begin
        fill_cnt <= '0;  // any gap breaks the run, line must refill
      end else if (fill_cnt != fill_max) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

endmodule

// File: rtl/fir_mac.sv
`timescale 1ns/100ps

module fir_mac (
  input  logic              clk,
  input  logic              rst,
  input  fas_pkg::window_t  window,
  input  logic              window_valid,
  output logic              fir_valid,
  output fas_pkg::sample_t  fir_d
);

  localparam int half = fas_pkg::num_taps / 2;

  // output clamp limits, sign-extended to accumulator width
  localparam fas_pkg::acc_t sat_max = (2 ** (fas_pkg::sample_w - 1)) - 1;
  localparam fas_pkg::acc_t sat_min = -(2 ** (fas_pkg::sample_w - 1));

  fas_pkg::acc_t    sum_lo_c;   // taps 0..15
  fas_pkg::acc_t    sum_hi_c;   // taps 16..31
  fas_pkg::acc_t    sum_lo_q;
  fas_pkg::acc_t    sum_hi_q;
  logic             s1_valid;

  fas_pkg::acc_t    total_c;
  fas_pkg::acc_t    scaled_c;
  fas_pkg::sample_t sat_c;

  ////////////////////////////////////////////////////////////
  // stage 1: products and two partial sums
  ////////////////////////////////////////////////////////////

  always_comb begin
    sum_lo_c = '0;
    sum_hi_c = '0;
    for (int i = 0; i < half; i++) begin
      // both operands widened first so the product is signed and exact
      sum_lo_c += fas_pkg::acc_t'(window[i]) * fas_pkg::acc_t'(fas_pkg::fir_coef[i]);
      sum_hi_c += fas_pkg::acc_t'(window[i+half])
                  * fas_pkg::acc_t'(fas_pkg::fir_coef[i+half]);
    end
  end

  // partial sums only load with a full window behind them
  always_ff @(posedge clk) begin
    if (window_valid) begin
      sum_lo_q <= sum_lo_c;
      sum_hi_q <= sum_hi_c;
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 2: final add, scale, clamp
  ////////////////////////////////////////////////////////////

  always_comb begin
    total_c  = sum_lo_q + sum_hi_q;
    scaled_c = total_c >>> fas_pkg::coef_frac;  // floor, drops q.16 fraction

    if (scaled_c > sat_max) begin
      sat_c = fas_pkg::sample_t'(sat_max);
    end else if (scaled_c < sat_min) begin
      sat_c = fas_pkg::sample_t'(sat_min);
    end else begin
      sat_c = fas_pkg::sample_t'(scaled_c);  // in range, low bits suffice
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      fir_valid <= 1'b0;
      fir_d     <= '0;
    end else begin
      s1_valid  <= window_valid;
      fir_valid <= s1_valid;  // two cycles after window_valid
      if (s1_valid) begin
        fir_d <= sat_c;  // holds last result between strobes
      end
    end
  end

endmodule

// File: rtl/frame_collector.sv
`timescale 1ns/100ps

module frame_collector #(
  parameter int FRAME_LEN = fas_pkg::frame_len_default
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  fir_valid,
  input  fas_pkg::sample_t                      fir_d,
  output logic                                  frame_valid,
  output logic [FRAME_LEN*fas_pkg::sample_w-1:0] frame_d
);

  localparam int idx_w = (FRAME_LEN > 1) ? $clog2(FRAME_LEN) : 1;
  localparam logic [idx_w-1:0] idx_last = idx_w'(FRAME_LEN - 1);

  logic [idx_w-1:0]                      idx;       // next slot to fill
  logic [FRAME_LEN*fas_pkg::sample_w-1:0] frame_q;   // frame under assembly
  logic [FRAME_LEN*fas_pkg::sample_w-1:0] frame_c;   // frame_q plus this sample
  logic                                  last_c;

  ////////////////////////////////////////////////////////////
  // assembly
  ////////////////////////////////////////////////////////////

  // slot 0 sits at the low end and holds the oldest sample
  always_comb begin
    frame_c = frame_q;
    frame_c[idx*fas_pkg::sample_w +: fas_pkg::sample_w] = fir_d;
  end

  assign last_c = fir_valid && (idx == idx_last);

  always_ff @(posedge clk) begin
    if (fir_valid) begin
      frame_q <= frame_c;
    end
  end

  ////////////////////////////////////////////////////////////
  // index and output
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      idx         <= '0;
      frame_valid <= 1'b0;
      frame_d     <= '0;
    end else begin
      frame_valid <= last_c;
      if (last_c) begin
        frame_d <= frame_c;  // last sample goes straight in with the rest
        idx     <= '0;
      end else if (fir_valid) begin
        idx <= idx + 1'b1;
      end else begin
        idx <= '0;  // gap drops whatever was partly collected
      end
    end
  end

endmodule

// File: rtl/fas_top.sv
`timescale 1ns/100ps

module fas_top #(
  parameter int FRAME_LEN = fas_pkg::frame_len_default
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  data_valid,
  input  fas_pkg::sample_t                      data,
  output logic                                  fir_valid,
  output fas_pkg::sample_t                      fir_d,
  output logic                                  frame_valid,
  output logic [FRAME_LEN*fas_pkg::sample_w-1:0] frame_d
);

  ////////////////////////////////////////////////////////////
  // filter: tap line then two-stage mac
  ////////////////////////////////////////////////////////////

  fas_pkg::window_t window;        // newest sample in element 0
  logic             window_valid;  // one cycle after the completing sample

  fir_tap_line u_tap_line (
    .clk          (clk),
    .rst          (rst),
    .data_valid   (data_valid),
    .data         (data),
    .window       (window),
    .window_valid (window_valid)
  );

  // 3 cycles from sample in to fir_valid in total
  fir_mac u_mac (
    .clk          (clk),
    .rst          (rst),
    .window       (window),
    .window_valid (window_valid),
    .fir_valid    (fir_valid),
    .fir_d        (fir_d)
  );

  ////////////////////////////////////////////////////////////
  // serial to parallel
  ////////////////////////////////////////////////////////////

  frame_collector #(
    .FRAME_LEN (FRAME_LEN)
  ) u_collector (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),  // also a top-level output
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame_d     (frame_d)
  );

endmodule

// File: tb/fas_props.sv
`timescale 1ns/100ps

module fas_props (
  input logic clk,
  input logic rst,
  input logic data_valid,
  input logic fir_valid,
  input logic frame_valid
);

  int fail_cnt = 0;  // failed assertions so far, read by the testbench monitor

  ////////////////////////////////////////////////////////////
  // reset behaviour
  ////////////////////////////////////////////////////////////

  // strobes stay quiet while reset is held
  a_quiet_in_reset : assert property (@(posedge clk) rst |-> (!fir_valid && !frame_valid))
    else begin
      fail_cnt++;
      $error("output strobe high while rst is asserted");
    end

  ////////////////////////////////////////////////////////////
  // strobe ordering
  ////////////////////////////////////////////////////////////

  // a frame is only released by the sample that completed it
  a_frame_after_fir : assert property (@(posedge clk) disable iff (rst)
    frame_valid |-> $past(fir_valid))
    else begin
      fail_cnt++;
      $error("frame_valid without fir_valid one cycle before");
    end

  // tap line plus two mac stages give a latency of 3
  a_fir_latency : assert property (@(posedge clk) disable iff (rst)
    fir_valid |-> $past(data_valid, 3))
    else begin
      fail_cnt++;
      $error("fir_valid without data_valid three cycles before");
    end

endmodule

// File: tb/tb_fas.sv
`timescale 1ns/100ps

module tb_fas;

  localparam int FRAME_LEN      = 16;
  localparam int frame_bits     = FRAME_LEN * fas_pkg::sample_w;
  localparam int num_taps       = fas_pkg::num_taps;
  localparam int rst_cycles     = 16;
  localparam int settle_cycles  = 4;   // idle cycles checked after reset
  localparam int drain_cycles   = 6;   // filter and frame latency plus slack
  localparam int timeout_margin = 64;
  localparam int num_rows       = 7;

  // stimulus kinds
  localparam int kind_impulse = 0;
  localparam int kind_random  = 1;
  localparam int kind_sat_pos = 2;  // signs follow the taps
  localparam int kind_sat_neg = 3;  // signs against the taps
  localparam int kind_const   = 4;

  localparam fas_pkg::sample_t full_pos = 16'sh7fff;
  localparam fas_pkg::sample_t full_neg = 16'sh8000;

  typedef logic [frame_bits-1:0] word_t;  // wide enough for any compared value

  typedef struct {
    string name;
    int    len;    // burst length in samples
    int    kind;
    int    value;  // impulse height or constant level
    int    gap;    // idle cycles after the burst
  } row_t;

  logic             clk = 1'b0;
  logic             rst;
  logic             data_valid;
  fas_pkg::sample_t data;
  logic             fir_valid;
  fas_pkg::sample_t fir_d;
  logic             frame_valid;
  word_t            frame_d;

  int    seed = 16035;
  row_t  rows [num_rows];
  string cur_name = "reset";

  // reference model state
  fas_pkg::sample_t hist [num_taps];  // element 0 newest
  int               run_len = 0;      // consecutive samples up to num_taps
  word_t            part_frame = '0;
  int               part_n = 0;

  // expected items that the monitor pops
  fas_pkg::sample_t fir_exp_q [$];
  string            fir_name_q [$];
  word_t            frame_exp_q [$];
  string            frame_name_q [$];

  int fir_seen = 0;
  int frame_seen = 0;
  int cycle_cnt = 0;
  int timeout_limit = 1000000;  // replaced once the table is known

  string            exp_name;
  fas_pkg::sample_t exp_y;
  word_t            exp_frame;

  always #4 clk = ~clk;  // 8 ns period

  fas_top #(
    .FRAME_LEN (FRAME_LEN)
  ) DUT (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame_d     (frame_d)
  );

  bind fas_top fas_props u_props (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .fir_valid   (fir_valid),
    .frame_valid (frame_valid)
  );

  ////////////////////////////////////////////////////////////
  // error handling and checks
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      fail_run($sformatf("mismatch in %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  // everything reads zero while nothing has been filtered
  task automatic check_idle_outputs(input string name);
    check_value({name, " fir_valid"}, '0, word_t'(fir_valid));
    check_value({name, " frame_valid"}, '0, word_t'(frame_valid));
    check_value({name, " fir_d"}, '0, word_t'($unsigned(fir_d)));
    check_value({name, " frame_d"}, '0, frame_d);
  endtask

  ////////////////////////////////////////////////////////////
  // test table and stimulus
  ////////////////////////////////////////////////////////////

  task automatic fill_table();
    rows[0] = '{"impulse",     48, kind_impulse, 16384, 4};
    rows[1] = '{"random",     200, kind_random,      0, 5};
    rows[2] = '{"sat_pos",     32, kind_sat_pos,     0, 2};
    rows[3] = '{"sat_neg",     32, kind_sat_neg,     0, 2};
    rows[4] = '{"gap_before",  40, kind_random,      0, 3};  // partial frame dropped
    rows[5] = '{"gap_after",   50, kind_random,      0, 6};  // refill of 32 first
    rows[6] = '{"constant",    64, kind_const,    1000, 8};
  endtask

  // sample k of a burst
  function automatic fas_pkg::sample_t stim_sample(input int kind, input int k, input int value);
    logic neg_tap;
    neg_tap = 1'b0;
    if (k < num_taps) begin
      neg_tap = fas_pkg::fir_coef[num_taps-1-k] < 0;  // sample k lands on tap 31-k
    end
    case (kind)
      kind_impulse: return (k == num_taps - 1) ? fas_pkg::sample_t'(value) : '0;
      kind_random:  return fas_pkg::sample_t'($random(seed));
      kind_sat_pos: return neg_tap ? full_neg : full_pos;
      kind_sat_neg: return neg_tap ? full_pos : full_neg;
      default:      return fas_pkg::sample_t'(value);
    endcase
  endfunction

  // outputs a burst of len samples should give
  function automatic int outputs_for(input int len);
    return (len >= num_taps) ? len - (num_taps - 1) : 0;
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // window sum shifted down by the fraction bits and clamped
  function automatic fas_pkg::sample_t model_output();
    longint acc;
    acc = 0;
    for (int i = 0; i < num_taps; i++) begin
      acc += longint'(hist[i]) * longint'(fas_pkg::fir_coef[i]);
    end
    acc = acc >>> fas_pkg::coef_frac;
    if (acc > longint'(full_pos)) begin
      return full_pos;
    end
    if (acc < longint'(full_neg)) begin
      return full_neg;
    end
    return fas_pkg::sample_t'(acc);
  endfunction

  task automatic model_step(input logic v, input fas_pkg::sample_t s);
    fas_pkg::sample_t y;
    if (!v) begin
      run_len    = 0;  // idle cycle restarts the fill and the framing
      part_n     = 0;
      part_frame = '0;
    end else begin
      for (int i = num_taps - 1; i > 0; i--) begin
        hist[i] = hist[i-1];
      end
      hist[0] = s;
      if (run_len < num_taps) begin
        run_len++;
      end
      if (run_len == num_taps) begin
        y = model_output();
        fir_exp_q.push_back(y);
        fir_name_q.push_back(cur_name);
        part_frame[part_n*fas_pkg::sample_w +: fas_pkg::sample_w] = y;  // oldest in word 0
        part_n++;
        if (part_n == FRAME_LEN) begin
          frame_exp_q.push_back(part_frame);
          frame_name_q.push_back(cur_name);
          part_n = 0;
        end
      end
    end
  endtask

  task automatic drive_sample(input logic v, input fas_pkg::sample_t s);
    @(posedge clk);
    #1;
    data_valid = v;
    data       = s;
    model_step(v, s);
  endtask

  ////////////////////////////////////////////////////////////
  // monitor and timeout
  ////////////////////////////////////////////////////////////

  // registered outputs are stable at the falling edge
  always @(negedge clk) begin
    if (DUT.u_props.fail_cnt != 0) begin
      fail_run("a concurrent assertion on the DUT ports failed");
    end
    if (fir_valid) begin
      fir_seen++;
      if (fir_exp_q.size() == 0) begin
        fail_run($sformatf("fir_valid arrived with no output expected, during %s", cur_name));
      end else begin
        exp_name = fir_name_q.pop_front();
        exp_y    = fir_exp_q.pop_front();
        check_value({exp_name, " fir_d"}, word_t'($unsigned(exp_y)), word_t'($unsigned(fir_d)));
      end
    end
    if (frame_valid) begin
      frame_seen++;
      if (frame_exp_q.size() == 0) begin
        fail_run($sformatf("frame_valid arrived with no frame expected, during %s", cur_name));
      end else begin
        exp_name  = frame_name_q.pop_front();
        exp_frame = frame_exp_q.pop_front();
        check_value({exp_name, " frame_d"}, exp_frame, frame_d);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > timeout_limit) begin
      fail_run($sformatf("timeout: the run did not finish within %0d cycles", timeout_limit));
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int total_fir;
    int total_frames;
    int total_cycles;

    rst        = 1'b1;
    data_valid = 1'b0;
    data       = '0;
    for (int i = 0; i < num_taps; i++) begin
      hist[i] = '0;
    end

    fill_table();
    total_fir    = 0;
    total_frames = 0;
    total_cycles = 0;
    for (int r = 0; r < num_rows; r++) begin
      total_fir    += outputs_for(rows[r].len);
      total_frames += outputs_for(rows[r].len) / FRAME_LEN;  // whole frames only
      total_cycles += rows[r].len + rows[r].gap;
    end
    timeout_limit = total_cycles + timeout_margin;

    repeat (rst_cycles) begin
      @(negedge clk);
      check_idle_outputs("reset");
    end
    @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (settle_cycles) begin
      @(negedge clk);
      check_idle_outputs("after reset");
    end

    for (int r = 0; r < num_rows; r++) begin
      cur_name = rows[r].name;
      for (int k = 0; k < rows[r].len; k++) begin
        drive_sample(1'b1, stim_sample(rows[r].kind, k, rows[r].value));
      end
      for (int g = 0; g < rows[r].gap; g++) begin
        drive_sample(1'b0, '0);
      end
    end

    cur_name = "drain";
    repeat (drain_cycles) @(posedge clk);  // covers the 3-cycle filter and 1-cycle frame latency

    if (fir_exp_q.size() != 0) begin
      fail_run($sformatf("%0d expected filter outputs never appeared", fir_exp_q.size()));
    end
    if (frame_exp_q.size() != 0) begin
      fail_run($sformatf("%0d expected frames never appeared", frame_exp_q.size()));
    end
    check_value("output count", word_t'(total_fir), word_t'(fir_seen));
    check_value("frame count", word_t'(total_frames), word_t'(frame_seen));

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: src.f
rtl/fas_pkg.sv
rtl/fir_tap_line.sv
rtl/fir_mac.sv
rtl/frame_collector.sv
rtl/fas_top.sv
tb/fas_props.sv
tb/tb_fas.sv

// File: Makefile
# Verilator build and run of the filter and framing testbench

TOP       ?= tb_fas
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= NO ERRORS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: TOP FILELIST OBJ_DIR VERILATOR VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
